//--- bench/mmio_bus_checker.sv
`timescale 1ns/1ps

module mmio_bus_checker (
   input logic clk,
   input logic arst_n,
   input logic rd_en,
   input logic wr_en,
   input logic ram_rd_en,
   input logic led_rd_en,
   input logic uart_rd_en,
   input logic rd_valid,
   input logic uart_tx,
   input logic uart_busy
);

   int fail_count = 0; // read by the testbench at the end of the run.

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n) !(rd_en && wr_en))
      else begin
         $error("rd_en and wr_en high in the same cycle");
         fail_count++;
      end

   a_one_target: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0({ram_rd_en, led_rd_en, uart_rd_en}))
      else begin
         $error("more than one target read strobe high");
         fail_count++;
      end

   a_rd_latency: assert property (@(posedge clk) disable iff (!arst_n) rd_en |-> ##3 rd_valid)
      else begin
         $error("read without rd_valid three cycles later");
         fail_count++;
      end

   a_no_extra_valid: assert property (@(posedge clk) disable iff (!arst_n)
      rd_valid |-> $past(rd_en, 3))
      else begin
         $error("rd_valid without a read three cycles earlier");
         fail_count++;
      end

   a_tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n) !uart_busy |-> uart_tx)
      else begin
         $error("tx low while the uart is idle");
         fail_count++;
      end

endmodule

bind mmio_bus mmio_bus_checker u_checker (
   .clk(clk),
   .arst_n(arst_n),
   .rd_en(rd_en),
   .wr_en(wr_en),
   .ram_rd_en(ram_rd_en),
   .led_rd_en(led_rd_en),
   .uart_rd_en(uart_rd_en),
   .rd_valid(rd_valid),
   .uart_tx(uart_tx),
   .uart_busy(u_uart.busy)
);

//--- bench/mmio_bus_tb.sv
`timescale 1ns/1ps

module mmio_bus_tb;

   localparam int ram_n = 64;
   localparam int edge_n = 16;
   localparam int led_n = 32;
   localparam int uart_n = 6;
   localparam int frame_clks = 10 * mmio_pkg::uart_clks_per_bit;
   localparam int cycle_limit = (5 + (2 * ram_n + 8) + (4 * edge_n + ram_n + 8) + 10 * led_n
                                 + (uart_n + 3) * (frame_clks + 20)) * 3 / 2;

   logic            clk;
   logic            arst_n;
   logic            rd_en;
   logic            wr_en;
   mmio_pkg::addr_t addr;
   mmio_pkg::word_t wr_data;
   mmio_pkg::word_t rd_data;
   logic            rd_valid;
   logic            led;
   logic            uart_tx;

   integer          seed;
   int              cyc;
   int              errors;
   int              checks;
   int              tests;
   int              last_tx_edge;
   mmio_pkg::word_t ram_mirror [0:mmio_pkg::ram_words-1];
   mmio_pkg::word_t led_model;
   mmio_pkg::word_t exp_word;
   mmio_pkg::word_t last_rd;
   mmio_pkg::word_t expect_q [$];
   mmio_pkg::byte_t tx_expect [$];
   mmio_pkg::byte_t rx_byte;
   logic [10:0]     written [$];

   mmio_bus uut (
      .clk(clk), .arst_n(arst_n),
      .rd_en(rd_en), .wr_en(wr_en), .addr(addr), .wr_data(wr_data),
      .rd_data(rd_data), .rd_valid(rd_valid), .led(led), .uart_tx(uart_tx)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cyc = cyc + 1;
      if (cyc > cycle_limit) begin
         $display("timeout: run still going after %0d cycles", cycle_limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic check_word(input mmio_pkg::word_t got, input mmio_pkg::word_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_byte(input mmio_pkg::byte_t got, input mmio_pkg::byte_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // a frame occupies the 40 cycles after the edge that follows the write.
   function automatic logic uart_busy_at(input int edge_idx);
      return (edge_idx > last_tx_edge) && (edge_idx <= last_tx_edge + frame_clks);
   endfunction

   function automatic mmio_pkg::word_t model_read(input mmio_pkg::addr_t a);
      case (mmio_pkg::region_t'(a[15:14]))
         mmio_pkg::region_ram: return (a[13:2] < mmio_pkg::ram_words) ? ram_mirror[a[12:2]] : '0;
         mmio_pkg::region_led: return (a[13:0] == 14'd0) ? led_model : '0;
         mmio_pkg::region_uart: begin
            if (a[13:0] == 14'(mmio_pkg::uart_status_off)) begin
               return {31'd0, uart_busy_at(cyc + 1)};
            end
            return '0;
         end
         default: return '0; // unmapped.
      endcase
   endfunction

   task automatic model_write(input mmio_pkg::addr_t a, input mmio_pkg::word_t d);
      case (mmio_pkg::region_t'(a[15:14]))
         mmio_pkg::region_ram: begin
            if (a[13:2] < mmio_pkg::ram_words) ram_mirror[a[12:2]] = d;
         end
         mmio_pkg::region_led: begin
            if (a[13:0] == 14'd0) led_model = d;
         end
         mmio_pkg::region_uart: begin
            // a write during a frame is lost.
            if ((a[13:0] == 14'd0) && !uart_busy_at(cyc + 1)) begin
               last_tx_edge = cyc + 1;
               tx_expect.push_back(d[7:0]);
            end
         end
         default: ;
      endcase
   endtask

   task automatic bus_write(input mmio_pkg::addr_t a, input mmio_pkg::word_t d);
      @(negedge clk);
      rd_en = 1'b0;
      wr_en = 1'b1;
      addr = a;
      wr_data = d;
      model_write(a, d);
   endtask

   task automatic bus_read(input mmio_pkg::addr_t a);
      @(negedge clk);
      rd_en = 1'b1;
      wr_en = 1'b0;
      addr = a;
      expect_q.push_back(model_read(a));
   endtask

   task automatic bus_idle();
      @(negedge clk);
      rd_en = 1'b0;
      wr_en = 1'b0;
   endtask

   task automatic drain();
      while (expect_q.size() != 0) @(negedge clk);
   endtask

   task automatic read_status(output mmio_pkg::word_t v);
      bus_read(16'h8000 | 16'(mmio_pkg::uart_status_off));
      bus_idle();
      drain();
      v = last_rd;
   endtask

   task automatic wait_uart_idle();
      mmio_pkg::word_t v;
      do begin
         read_status(v);
      end while (v[0]);
   endtask

   task automatic finish_test(input string name, input int e0);
      tests++;
      $display("test %0d %s: %s (%0d errors)", tests, name, (errors == e0) ? "ok" : "bad",
               errors - e0);
   endtask

   // every read answer is matched against the oldest outstanding read.
   always @(negedge clk) begin
      if (arst_n === 1'b1 && rd_valid === 1'b1) begin
         if (expect_q.size() == 0) begin
            errors++;
            $display("rd_valid at %0t with no read outstanding", $time);
         end else begin
            exp_word = expect_q.pop_front();
            check_word(rd_data, exp_word, "read data");
         end
         last_rd = rd_data;
      end
   end

   // serial line decoder, samples near mid-bit.
   initial begin
      forever begin
         @(negedge clk);
         if (arst_n === 1'b1 && uart_tx === 1'b0) begin
            repeat (mmio_pkg::uart_clks_per_bit / 2) @(negedge clk);
            check_bit(uart_tx, 1'b0, "start bit");
            for (int i = 0; i < 8; i++) begin
               repeat (mmio_pkg::uart_clks_per_bit) @(negedge clk);
               rx_byte[i] = uart_tx;
            end
            repeat (mmio_pkg::uart_clks_per_bit) @(negedge clk);
            check_bit(uart_tx, 1'b1, "stop bit");
            if (tx_expect.size() == 0) begin
               errors++;
               $display("byte %h appeared on tx at %0t without an accepted write", rx_byte, $time);
            end else begin
               check_byte(rx_byte, tx_expect.pop_front(), "tx byte");
            end
         end
      end
   end

   initial begin
      int              e0;
      logic [10:0]     idx;
      mmio_pkg::word_t status;
      clk = 1'b0;
      arst_n = 1'b0;
      rd_en = 1'b0;
      wr_en = 1'b0;
      addr = '0;
      wr_data = '0;
      seed = 32'h3f60;
      cyc = 0;
      errors = 0;
      checks = 0;
      tests = 0;
      last_tx_edge = -1000;
      led_model = '0;
      last_rd = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      e0 = errors;
      for (int i = 0; i < ram_n; i++) begin
         idx = 11'($random(seed));
         written.push_back(idx);
         bus_write({3'b000, idx, 2'b00}, $random(seed));
      end
      for (int i = 0; i < ram_n; i++) begin
         idx = written[$unsigned($random(seed)) % written.size()];
         bus_read({3'b000, idx, 2'b00}); // back to back.
      end
      bus_idle();
      drain();
      finish_test("ram random", e0);

      e0 = errors;
      for (int i = 0; i < edge_n; i++) begin
         bus_read({3'b001, 11'($random(seed)), 2'b00}); // past the last ram word.
         bus_read({2'b11, 14'($random(seed))});
      end
      for (int i = 0; i < edge_n; i++) begin
         bus_write({3'b001, 11'($random(seed)), 2'b00}, $random(seed));
         bus_write({2'b11, 14'($random(seed))}, $random(seed));
      end
      foreach (written[i]) bus_read({3'b000, written[i], 2'b00});
      bus_read(16'h4000);
      bus_idle();
      drain();
      check_bit(led, led_model[0], "led after stray writes");
      finish_test("out of range", e0);

      e0 = errors;
      for (int i = 0; i < led_n; i++) begin
         bus_write(16'h4000, $random(seed));
         bus_idle();
         bus_idle();
         check_bit(led, led_model[0], "led pin");
         bus_read(16'h4000);
         bus_read({2'b01, 12'($random(seed)) | 12'd1, 2'b00});
      end
      bus_idle();
      drain();
      finish_test("led register", e0);

      e0 = errors;
      for (int i = 0; i < uart_n; i++) begin
         wait_uart_idle();
         bus_write(16'h8000, $random(seed));
         read_status(status);
         check_bit(status[0], 1'b1, "busy after write");
         bus_read(16'h8008); // unused offset reads zero.
      end
      wait_uart_idle();
      finish_test("uart bytes", e0);

      e0 = errors;
      wait_uart_idle();
      bus_write(16'h8000, $random(seed));
      repeat (6) bus_idle();
      bus_write(16'h8000, $random(seed)); // lands mid frame.
      wait_uart_idle();
      bus_write(16'h8000, $random(seed));
      wait_uart_idle();
      if (tx_expect.size() != 0) begin
         errors++;
         $display("%0d accepted bytes never appeared on tx", tx_expect.size());
      end
      finish_test("uart busy drop", e0);

      errors = errors + uut.u_checker.fail_count;
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- hw/bus_decode.sv
`timescale 1ns/1ps

module bus_decode (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             rd_en,
   input  logic             wr_en,
   input  mmio_pkg::addr_t  addr,
   input  mmio_pkg::word_t  wr_data,
   output logic             ram_rd_en,
   output logic             ram_wr_en,
   output logic             led_rd_en,
   output logic             led_wr_en,
   output logic             uart_rd_en,
   output logic             uart_wr_en,
   output logic             unmapped_rd,
   output logic [13:0]      t_addr,
   output mmio_pkg::word_t  t_wr_data
);

   mmio_pkg::region_t region;

   assign region = addr[15:14];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ram_rd_en   <= 1'b0;
         ram_wr_en   <= 1'b0;
         led_rd_en   <= 1'b0;
         led_wr_en   <= 1'b0;
         uart_rd_en  <= 1'b0;
         uart_wr_en  <= 1'b0;
         unmapped_rd <= 1'b0;
      end else begin
         ram_rd_en   <= rd_en && (region == mmio_pkg::region_ram);
         ram_wr_en   <= wr_en && (region == mmio_pkg::region_ram);
         led_rd_en   <= rd_en && (region == mmio_pkg::region_led);
         led_wr_en   <= wr_en && (region == mmio_pkg::region_led);
         uart_rd_en  <= rd_en && (region == mmio_pkg::region_uart);
         uart_wr_en  <= wr_en && (region == mmio_pkg::region_uart);
         // writes to region 3 simply fall through.
         unmapped_rd <= rd_en && (region == 2'd3);
      end
   end

   // offset and data follow the strobes by the same cycle.
   always_ff @(posedge clk) begin
      if (rd_en || wr_en) begin
         t_addr    <= addr[13:0];
         t_wr_data <= wr_data;
      end
   end

endmodule

//--- hw/led_reg.sv
`timescale 1ns/1ps

module led_reg (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             rd_en,
   input  logic             wr_en,
   input  logic [13:0]      addr,
   input  mmio_pkg::word_t  wr_data,
   output mmio_pkg::word_t  rd_data,
   output logic             rd_valid,
   output logic             led
);

   mmio_pkg::word_t value;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         value    <= '0;
         rd_valid <= 1'b0;
         rd_data  <= '0;
      end else begin
         if (wr_en && (addr == 14'd0)) begin
            value <= wr_data;
         end
         rd_valid <= rd_en;
         rd_data  <= (rd_en && (addr == 14'd0)) ? value : '0;
      end
   end

   assign led = value[0];

endmodule

//--- hw/mmio_bus.sv
`timescale 1ns/1ps

module mmio_bus (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             rd_en,
   input  logic             wr_en,
   input  mmio_pkg::addr_t  addr,
   input  mmio_pkg::word_t  wr_data,
   output mmio_pkg::word_t  rd_data,
   output logic             rd_valid,
   output logic             led,
   output logic             uart_tx
);

   logic            ram_rd_en, ram_wr_en, ram_rd_valid;
   logic            led_rd_en, led_wr_en, led_rd_valid;
   logic            uart_rd_en, uart_wr_en, uart_rd_valid;
   logic            unmapped_rd;
   logic [13:0]     t_addr;
   mmio_pkg::word_t t_wr_data;
   mmio_pkg::word_t ram_rd_data, led_rd_data, uart_rd_data;

   bus_decode u_decode (
      .clk(clk), .arst_n(arst_n),
      .rd_en(rd_en), .wr_en(wr_en), .addr(addr), .wr_data(wr_data),
      .ram_rd_en(ram_rd_en), .ram_wr_en(ram_wr_en),
      .led_rd_en(led_rd_en), .led_wr_en(led_wr_en),
      .uart_rd_en(uart_rd_en), .uart_wr_en(uart_wr_en),
      .unmapped_rd(unmapped_rd), .t_addr(t_addr), .t_wr_data(t_wr_data)
   );

   word_ram u_ram (
      .clk(clk), .arst_n(arst_n),
      .rd_en(ram_rd_en), .wr_en(ram_wr_en), .addr(t_addr), .wr_data(t_wr_data),
      .rd_data(ram_rd_data), .rd_valid(ram_rd_valid)
   );

   led_reg u_led (
      .clk(clk), .arst_n(arst_n),
      .rd_en(led_rd_en), .wr_en(led_wr_en), .addr(t_addr), .wr_data(t_wr_data),
      .rd_data(led_rd_data), .rd_valid(led_rd_valid), .led(led)
   );

   uart_tx u_uart (
      .clk(clk), .arst_n(arst_n),
      .rd_en(uart_rd_en), .wr_en(uart_wr_en), .addr(t_addr), .wr_data(t_wr_data),
      .rd_data(uart_rd_data), .rd_valid(uart_rd_valid), .tx(uart_tx)
   );

   read_return u_return (
      .clk(clk), .arst_n(arst_n),
      .ram_rd_valid(ram_rd_valid), .ram_rd_data(ram_rd_data),
      .led_rd_valid(led_rd_valid), .led_rd_data(led_rd_data),
      .uart_rd_valid(uart_rd_valid), .uart_rd_data(uart_rd_data),
      .unmapped_rd(unmapped_rd),
      .rd_valid(rd_valid), .rd_data(rd_data)
   );

endmodule

//--- hw/mmio_pkg.sv
package mmio_pkg;

   // byte address as issued by the master.
   typedef logic [15:0] addr_t;

   // bus data word.
   typedef logic [31:0] word_t;

   // one serial character.
   typedef logic [7:0] byte_t;

   // region select, addr[15:14].
   typedef logic [1:0] region_t;

   // address map.
   localparam region_t region_ram  = 2'd0;
   localparam region_t region_led  = 2'd1;
   localparam region_t region_uart = 2'd2;
   // value 3 is unmapped.

   // ram depth in 32-bit words.
   localparam int ram_words = 2048;

   // Serial bit time in clocks, short so a frame fits a quick simulation.
   localparam int uart_clks_per_bit = 4;

   // uart register offsets, data register sits at 0.
   localparam int uart_status_off = 4;

endpackage

//--- hw/read_return.sv
`timescale 1ns/1ps

module read_return (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             ram_rd_valid,
   input  mmio_pkg::word_t  ram_rd_data,
   input  logic             led_rd_valid,
   input  mmio_pkg::word_t  led_rd_data,
   input  logic             uart_rd_valid,
   input  mmio_pkg::word_t  uart_rd_data,
   input  logic             unmapped_rd,
   output logic             rd_valid,
   output mmio_pkg::word_t  rd_data
);

   logic unmapped_q;

   // the unmapped strobe skips the target stage, so it waits one cycle here.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         unmapped_q <= 1'b0;
         rd_valid   <= 1'b0;
      end else begin
         unmapped_q <= unmapped_rd;
         rd_valid   <= ram_rd_valid | led_rd_valid | uart_rd_valid | unmapped_q;
      end
   end

   // Idle targets drive zero, and an unmapped read contributes nothing,
   // so it returns zero.
   always_ff @(posedge clk) begin
      rd_data <= ram_rd_data | led_rd_data | uart_rd_data;
   end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             rd_en,
   input  logic             wr_en,
   input  logic [13:0]      addr,
   input  mmio_pkg::word_t  wr_data,
   output mmio_pkg::word_t  rd_data,
   output logic             rd_valid,
   output logic             tx
);

   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } state_t;

   state_t          state;
   logic [15:0]     bit_cnt;
   logic [2:0]      bit_idx;
   mmio_pkg::byte_t data_q;
   logic            busy;
   logic            accept;
   logic            bit_done;

   assign busy     = (state != st_idle);
   assign accept   = wr_en && (addr == 14'd0) && !busy; // writes while busy are lost.
   assign bit_done = (bit_cnt == mmio_pkg::uart_clks_per_bit - 1);

   always_ff @(posedge clk) begin
      if (accept) begin
         data_q <= wr_data[7:0];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= st_idle;
         bit_cnt <= '0;
         bit_idx <= '0;
         tx      <= 1'b1;
      end else begin
         bit_cnt <= bit_done ? '0 : bit_cnt + 16'd1;
         case (state)
            st_idle: begin
               bit_cnt <= '0;
               if (accept) begin
                  state <= st_start;
                  tx    <= 1'b0; // start bit.
               end
            end
            st_start: begin
               if (bit_done) begin
                  state   <= st_data;
                  bit_idx <= '0;
                  tx      <= data_q[0];
               end
            end
            st_data: begin
               if (bit_done) begin
                  if (bit_idx == 3'd7) begin
                     state <= st_stop;
                     tx    <= 1'b1;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                     tx      <= data_q[bit_idx + 3'd1]; // lsb first.
                  end
               end
            end
            st_stop: begin
               if (bit_done) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // only the status register reads back.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_valid <= 1'b0;
         rd_data  <= '0;
      end else begin
         rd_valid <= rd_en;
         if (rd_en && (addr == 14'(mmio_pkg::uart_status_off))) begin
            rd_data <= {31'd0, busy};
         end else begin
            rd_data <= '0;
         end
      end
   end

endmodule

//--- hw/word_ram.sv
`timescale 1ns/1ps

module word_ram (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             rd_en,
   input  logic             wr_en,
   input  logic [13:0]      addr,
   input  mmio_pkg::word_t  wr_data,
   output mmio_pkg::word_t  rd_data,
   output logic             rd_valid
);

   mmio_pkg::word_t mem [0:mmio_pkg::ram_words-1];

   logic        in_range;
   logic [10:0] word_idx;

   assign word_idx = addr[12:2]; // byte offset to word index.
   assign in_range = (addr[13:2] < mmio_pkg::ram_words);

   always_ff @(posedge clk) begin
      if (wr_en && in_range) begin
         mem[word_idx] <= wr_data;
      end
   end

   // Read data is forced to zero outside a read so that the return
   // stage can merge all targets with a plain OR.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_valid <= 1'b0;
         rd_data  <= '0;
      end else begin
         rd_valid <= rd_en;
         if (rd_en && in_range) begin
            rd_data <= mem[word_idx];
         end else begin
            rd_data <= '0; // out of range reads as zero.
         end
      end
   end

endmodule

//--- vlog.f
hw/mmio_pkg.sv
hw/bus_decode.sv
hw/word_ram.sv
hw/led_reg.sv
hw/uart_tx.sv
hw/read_return.sv
hw/mmio_bus.sv
bench/mmio_bus_checker.sv
bench/mmio_bus_tb.sv
